/* files.f */
common/noc_pkg.sv
noc_sender/noc_sender.sv
logic/flit_fifo.sv
noc_receiver/noc_receiver.sv
logic/noc_link_top.sv
test/noc_link_tb.sv

/* Makefile */
# Verilator build and run for the NoC link testbench

VERILATOR ?= verilator
TOP       ?= noc_link_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* test/noc_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_link_tb
    import noc_pkg::*;
();

    localparam int clk_period     = 10;
    localparam int reset_cycles   = 4;
    localparam int num_rows       = 10;
    localparam int settle_cycles  = 24;
    localparam int zero_len_watch = 20;

    localparam logic [addr_width-1:0] local_addr = 4'h3;
    localparam logic [addr_width-1:0] rx_addr    = 4'h5;

    // Back-pressure modes
    localparam logic [1:0] stall_none   = 2'd0;
    localparam logic [1:0] stall_random = 2'd1;
    localparam logic [1:0] stall_heavy  = 2'd2;

    typedef struct packed {
        logic [data_width-1:0] first_data;
        logic [len_width-1:0]  length;
        logic [addr_width-1:0] dest;
        logic [1:0]            stall;
        logic                  busy_strobe;
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  send_packet;
    pkt_req_t              req;
    logic [addr_width-1:0] my_router_addr;
    logic [addr_width-1:0] rx_router_addr;
    logic                  rx_stall = 1'b0;
    logic                  packet_done;
    logic                  packet_received;
    pkt_summary_t          summary;
    logic [drop_width-1:0] drop_count;

    row_t       rows [num_rows];
    logic [1:0] stall_mode    = stall_none;
    logic [1:0] stall_phase   = 2'd0;
    int         reports_seen  = 0;
    int         cycle_count   = 0;
    int         timeout_limit = 0;
    int         errors        = 0;
    int         checks        = 0;

    noc_link_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .send_packet     (send_packet),
        .req             (req),
        .my_router_addr  (my_router_addr),
        .rx_router_addr  (rx_router_addr),
        .rx_stall        (rx_stall),
        .packet_done     (packet_done),
        .packet_received (packet_received),
        .summary         (summary),
        .drop_count      (drop_count)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // Receiver back-pressure
    // Heavy mode lets one beat in four through
    always @(posedge clk) begin
        logic [31:0] rand_word;
        rand_word = $urandom;
        stall_phase <= stall_phase + 2'd1;
        case (stall_mode)
            stall_random: rx_stall <= rand_word[0];
            stall_heavy:  rx_stall <= (stall_phase != 2'd0);
            default:      rx_stall <= 1'b0;
        endcase
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && packet_received) begin
            reports_seen <= reports_seen + 1;
        end
    end

    always @(negedge clk) begin
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic fill_table();
        rows[0] = '{32'h0000_1000, 4'd1,  rx_addr, stall_none,   1'b0};
        rows[1] = '{32'h0000_2000, 4'd15, rx_addr, stall_none,   1'b0};
        rows[2] = '{32'h1234_5678, 4'd15, rx_addr, stall_random, 1'b0};
        rows[3] = '{32'hA5A5_0000, 4'd7,  rx_addr, stall_heavy,  1'b0};
        rows[4] = '{32'h0000_3000, 4'd6,  4'h9,    stall_none,   1'b0};
        rows[5] = '{32'h0000_4000, 4'd0,  rx_addr, stall_none,   1'b0};
        rows[6] = '{32'h0000_5000, 4'd10, rx_addr, stall_heavy,  1'b1};
        rows[7] = '{32'hFFFF_FFFA, 4'd12, rx_addr, stall_none,   1'b0};
        rows[8] = '{32'hFFFF_FFFF, 4'd9,  rx_addr, stall_random, 1'b0};
        rows[9] = '{32'h0000_6000, 4'd4,  4'hC,    stall_random, 1'b0};
    endtask

    function automatic int cycle_budget();
        int total;
        total = 0;
        for (int r = 0; r < num_rows; r++) begin
            total += 8 * int'(rows[r].length) + 40;
        end
        return total;
    endfunction

    // Sum of first up to first + len - 1 modulo 2^32
    function automatic logic [31:0] burst_sum(input logic [31:0] first,
                                              input logic [len_width-1:0] len);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < int'(len); i++) begin
            sum = sum + first + 32'(i);
        end
        return sum;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_for_idle();
        do @(negedge clk); while (!packet_done);
    endtask

    task automatic run_row(input int r);
        row_t         row;
        pkt_summary_t expected;
        int           reports_before;
        int           errors_before;
        logic [15:0]  drops_before;
        logic         expect_report;
        logic         expect_drop;
        row = rows[r];
        errors_before = errors;
        expect_report = (row.length != '0) && (row.dest == rx_addr);
        expect_drop   = (row.length != '0) && (row.dest != rx_addr);
        expected.src        = local_addr;
        expected.dest       = row.dest;
        expected.length     = row.length;
        expected.first_data = row.first_data;
        expected.checksum   = burst_sum(row.first_data, row.length);

        wait_for_idle();
        reports_before = reports_seen;
        drops_before   = drop_count;

        @(posedge clk);
        stall_mode  <= row.stall;
        send_packet <= 1'b1;
        req         <= '{first_data: row.first_data, length: row.length, dest: row.dest};
        @(posedge clk);
        send_packet <= 1'b0;
        // Second strobe lands while the burst is running
        if (row.busy_strobe) begin
            @(posedge clk);
            send_packet    <= 1'b1;
            req.first_data <= ~row.first_data;
            @(posedge clk);
            send_packet <= 1'b0;
        end

        if (expect_report) begin
            do @(negedge clk); while (!packet_received);
            compare_value("summary.src", 32'(summary.src), 32'(expected.src));
            compare_value("summary.dest", 32'(summary.dest), 32'(expected.dest));
            compare_value("summary.length", 32'(summary.length), 32'(expected.length));
            compare_value("summary.first_data", summary.first_data, expected.first_data);
            compare_value("summary.checksum", summary.checksum, expected.checksum);
        end else if (expect_drop) begin
            do @(negedge clk); while (drop_count == drops_before);
        end else begin
            repeat (zero_len_watch) begin
                @(negedge clk);
                compare_value("packet_done", 32'(packet_done), 32'd1);
            end
        end

        @(posedge clk);
        stall_mode <= stall_none;
        wait_for_idle();
        repeat (settle_cycles) @(negedge clk);
        compare_value("report count", 32'(reports_seen - reports_before), 32'(expect_report));
        compare_value("drop count", 32'(drop_count - drops_before), 32'(expect_drop));

        $display("row %0d: len %0d dest %h stall %0d, %0d errors", r, row.length, row.dest,
                 row.stall, errors - errors_before);
    endtask

    initial begin
        void'($urandom(88));
        reset          = 1'b1;
        send_packet    = 1'b0;
        req            = '0;
        my_router_addr = local_addr;
        rx_router_addr = rx_addr;

        fill_table();
        timeout_limit = cycle_budget();

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_value("packet_done after reset", 32'(packet_done), 32'd1);
        compare_value("packet_received after reset", 32'(packet_received), 32'd0);
        compare_value("drop_count after reset", 32'(drop_count), 32'd0);
        $display("reset: %0d errors", errors);

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end

        $display("rows run %0d, checks %0d, failures %0d", num_rows, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/noc_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_link_top
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  send_packet,
    input  pkt_req_t              req,
    input  logic [addr_width-1:0] my_router_addr,
    input  logic [addr_width-1:0] rx_router_addr,
    input  logic                  rx_stall,
    output logic                  packet_done,
    output logic                  packet_received,
    output pkt_summary_t          summary,
    output logic [drop_width-1:0] drop_count
);

    // Sender to buffer
    flit_t tx_flit;
    logic  tx_valid;
    logic  tx_ready;

    // Buffer to receiver
    flit_t rx_flit;
    logic  rx_valid;
    logic  rx_ready;

    noc_sender i_sender (
        .clk            (clk),
        .reset          (reset),
        .send_packet    (send_packet),
        .req            (req),
        .my_router_addr (my_router_addr),
        .packet_done    (packet_done),
        .tx_flit        (tx_flit),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready)
    );

    flit_fifo i_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_flit   (tx_flit),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_flit  (rx_flit),
        .out_valid (rx_valid),
        .out_ready (rx_ready)
    );

    noc_receiver i_receiver (
        .clk             (clk),
        .reset           (reset),
        .rx_flit         (rx_flit),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .rx_stall        (rx_stall),
        .rx_router_addr  (rx_router_addr),
        .packet_received (packet_received),
        .summary         (summary),
        .drop_count      (drop_count)
    );

endmodule

`default_nettype wire

/* noc_receiver/noc_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_receiver
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // Stream slave
    input  flit_t                 rx_flit,
    input  logic                  rx_valid,
    output logic                  rx_ready,

    // Back-pressure and local address
    input  logic                  rx_stall,
    input  logic [addr_width-1:0] rx_router_addr,

    // Report
    output logic                  packet_received,
    output pkt_summary_t          summary,
    output logic [drop_width-1:0] drop_count
);

    // High after the first flit of a packet until its last one
    logic         in_packet;
    pkt_summary_t cur;
    pkt_summary_t next_sum;

    logic accept;
    logic addr_match;

    assign rx_ready   = !rx_stall;
    assign accept     = rx_valid && rx_ready;
    assign addr_match = (next_sum.dest == rx_router_addr);

    // Running summary including the flit on the bus
    always_comb begin
        next_sum = cur;
        if (!in_packet) begin
            // Header fields come from the first flit
            next_sum.src        = rx_flit.src;
            next_sum.dest       = rx_flit.dest;
            next_sum.first_data = rx_flit.data;
            next_sum.length     = len_width'(1);
            next_sum.checksum   = rx_flit.data;
        end else begin
            next_sum.length   = cur.length + 1'b1;
            next_sum.checksum = cur.checksum + rx_flit.data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_packet       <= 1'b0;
            packet_received <= 1'b0;
            drop_count      <= '0;
        end else begin
            packet_received <= 1'b0;
            if (accept) begin
                in_packet <= !rx_flit.last;
                if (rx_flit.last) begin
                    if (addr_match) begin
                        packet_received <= 1'b1;
                    end else begin
                        drop_count <= drop_count + 1'b1;
                    end
                end
            end
        end
    end

    // Accumulator and the reported summary
    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= next_sum;
        end
        if (accept && rx_flit.last && addr_match) begin
            summary <= next_sum;
        end
    end

    // One report per packet
    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        packet_received |=> !packet_received
    );

endmodule

`default_nettype wire

/* logic/flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Write side
    input  flit_t in_flit,
    input  logic  in_valid,
    output logic  in_ready,

    // Read side
    output flit_t out_flit,
    output logic  out_valid,
    input  logic  out_ready
);

    flit_t mem [fifo_depth];

    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_cnt_width-1:0] count;

    logic full;
    logic wr_en;
    logic rd_en;

    function automatic logic [fifo_ptr_width-1:0] next_ptr(
        input logic [fifo_ptr_width-1:0] ptr
    );
        if (ptr == fifo_ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == fifo_cnt_width'(fifo_depth));

    // A full buffer still takes a flit when one leaves in the same cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= fifo_cnt_width'(fifo_depth)
    );

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        wr_en && full |-> rd_en
    );

endmodule

`default_nettype wire

/* noc_sender/noc_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_sender
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // Command side
    input  logic                  send_packet,
    input  pkt_req_t              req,
    input  logic [addr_width-1:0] my_router_addr,
    output logic                  packet_done,

    // Stream master
    output flit_t                 tx_flit,
    output logic                  tx_valid,
    input  logic                  tx_ready
);

    sender_state_t        state;
    logic [len_width-1:0] flits_left;

    logic take;
    logic advance;
    logic finish;

    // Zero length requests are dropped here
    assign take = (state == idle) && send_packet && (req.length != '0);

    // Accepted beat splits on the last flag
    assign advance = (state == send) && tx_ready && !tx_flit.last;
    assign finish  = (state == send) && tx_ready && tx_flit.last;

    assign tx_valid    = (state == send);
    assign packet_done = (state == idle);

    // FSM and remaining flit count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= idle;
            flits_left <= '0;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        state      <= send;
                        flits_left <= req.length - 1'b1;
                    end
                end
                send: begin
                    if (finish) begin
                        state <= idle;
                    end else if (advance) begin
                        flits_left <= flits_left - 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Flit payload holds the running data word
    always_ff @(posedge clk) begin
        if (take) begin
            tx_flit.data <= req.first_data;
            tx_flit.last <= (req.length == len_width'(1));
            tx_flit.dest <= req.dest;
            tx_flit.src  <= my_router_addr;
        end else if (advance) begin
            tx_flit.data <= tx_flit.data + 1'b1;
            // Next beat is final when one remains after it
            tx_flit.last <= (flits_left == len_width'(1));
        end
    end

    // A stalled beat stays put
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_flit)
    );

    // Final beat closes the burst
    a_last_ends_burst: assert property (
        @(posedge clk) disable iff (reset)
        tx_valid && tx_ready && tx_flit.last |=> !tx_valid
    );

    // Any other accepted beat is followed by more of the same packet
    a_no_early_end: assert property (
        @(posedge clk) disable iff (reset)
        tx_valid && tx_ready && !tx_flit.last |=> tx_valid && $stable(tx_flit.dest)
    );

endmodule

`default_nettype wire

/* common/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    // Link field widths
    localparam int data_width = 32;
    localparam int addr_width = 4;
    localparam int len_width  = 4;
    localparam int drop_width = 16;

    // Flit buffer sizing
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

    // Sender FSM
    typedef enum logic [0:0] {
        idle = 1'b0,
        send = 1'b1
    } sender_state_t;

    // One 41-bit beat on the stream
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic [addr_width-1:0] dest;
        logic [addr_width-1:0] src;
    } flit_t;

    // Send request from the user side
    typedef struct packed {
        logic [data_width-1:0] first_data;
        logic [len_width-1:0]  length;
        logic [addr_width-1:0] dest;
    } pkt_req_t;

    // Per-packet report from the receiver
    typedef struct packed {
        logic [addr_width-1:0] src;
        logic [addr_width-1:0] dest;
        logic [len_width-1:0]  length;
        logic [data_width-1:0] first_data;
        logic [data_width-1:0] checksum;
    } pkt_summary_t;

endpackage

`default_nettype wire
